//--- Makefile
# Verilator build and run of the ADPCM-A decoder testbench
SIM      ?= verilator
TOP      ?= adpcma_tb
FILELIST ?= project.f
OBJ_DIR  ?= obj_dir
FLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, exit status is the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- design/adpcma_config.svh
// Fixed at six channels since ring depth equals channel count; widths are not meant to change
`ifndef ADPCMA_CONFIG_SVH
`define ADPCMA_CONFIG_SVH

// Channels, also the number of ring stages
`define ADPCMA_NUM_CH 6

// Highest adaptive step index
`define ADPCMA_STEP_MAX 48

// Channel accumulator, wraps on overflow
`define ADPCMA_ACC_W 15

// Remaining datapath widths
`define ADPCMA_NIB_W 4
`define ADPCMA_STEP_W 6
`define ADPCMA_INC_W 12
`define ADPCMA_PCM_W 16

// Enough bits for slot numbers 0 to 5
`define ADPCMA_SLOT_W 3

`endif

//--- design/adpcma_decoder.sv
// Ring is exactly six stages, one channel per stage; a visit's nibble or clear shows one frame later
`timescale 1ns/1ps
`include "adpcma_config.svh"

module adpcma_decoder
    import adpcma_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cen,
    input  logic    apply,
    input  logic    clr,
    input  nibble_t nib,
    output sample_t pcm
);

    localparam step_idx_t STEP_MAX = step_idx_t'(`ADPCMA_STEP_MAX);

    // Accumulator and step index, one pair per stage
    acc_t      acc_s1, acc_s2, acc_s3, acc_s4, acc_s5, acc_s6;
    step_idx_t step_s1, step_s2, step_s3, step_s4, step_s5, step_s6;

    // Control travelling with the channel
    logic apply_s2, apply_s3, apply_s4;
    logic clr_s2, clr_s3, clr_s4;
    logic sign_s2, sign_s3;

    // LUT address, registered at stage I
    step_idx_t lut_step;
    logic [2:0] lut_mag;
    // LUT output, lines up with stage III
    inc_t lut_inc;
    // Signed increment for stage IV
    acc_t inc_s4;

    // Adapted step before the clamp
    step_idx_t step_next;
    step_idx_t step_adapt;

    adpcma_step_lut u_lut (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .step  (lut_step),
        .mag   (lut_mag),
        .inc   (lut_inc)
    );

    // Step adaptation from magnitude code
    always_comb begin
        case (nib[2:0])
            3'd4:    step_next = step_s1 + step_idx_t'(2);
            3'd5:    step_next = step_s1 + step_idx_t'(5);
            3'd6:    step_next = step_s1 + step_idx_t'(7);
            3'd7:    step_next = step_s1 + step_idx_t'(9);
            // Codes 0..3 walk down, floor at 0
            default: step_next = (step_s1 == '0) ? '0 : step_s1 - step_idx_t'(1);
        endcase
        // 48 + 9 still fits 6 bits
        step_adapt = (step_next > STEP_MAX) ? STEP_MAX : step_next;
    end

    // Stage II value is the channel just visited
    assign pcm = {acc_s2[`ADPCMA_ACC_W-1], acc_s2};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_s1   <= '0;
            acc_s2   <= '0;
            acc_s3   <= '0;
            acc_s4   <= '0;
            acc_s5   <= '0;
            acc_s6   <= '0;
            step_s1  <= '0;
            step_s2  <= '0;
            step_s3  <= '0;
            step_s4  <= '0;
            step_s5  <= '0;
            step_s6  <= '0;
            apply_s2 <= 1'b0;
            apply_s3 <= 1'b0;
            apply_s4 <= 1'b0;
            clr_s2   <= 1'b0;
            clr_s3   <= 1'b0;
            clr_s4   <= 1'b0;
        end else if (cen) begin
            // I: adapt step, LUT uses the old index
            acc_s2   <= acc_s1;
            step_s2  <= clr ? '0 : (apply ? step_adapt : step_s1);
            apply_s2 <= apply;
            clr_s2   <= clr;
            // II: carry sign while the LUT reads
            acc_s3   <= acc_s2;
            step_s3  <= step_s2;
            apply_s3 <= apply_s2;
            clr_s3   <= clr_s2;
            // III: increment arrives, negate below
            acc_s4   <= acc_s3;
            step_s4  <= step_s3;
            apply_s4 <= apply_s3;
            clr_s4   <= clr_s3;
            // IV: accumulate, wraps at 15 bits
            if (clr_s4) begin
                acc_s5 <= '0;
            end else if (apply_s4) begin
                acc_s5 <= acc_s4 + inc_s4;
            end else begin
                acc_s5 <= acc_s4;
            end
            step_s5  <= step_s4;
            // V and VI close the loop
            acc_s6   <= acc_s5;
            step_s6  <= step_s5;
            acc_s1   <= acc_s6;
            step_s1  <= step_s6;
        end
    end

    // Datapath payload
    always_ff @(posedge clk) begin
        if (cen) begin
            lut_step <= step_s1;
            lut_mag  <= nib[2:0];
            sign_s2  <= nib[3];
            sign_s3  <= sign_s2;
            // Two's complement when sign bit set
            inc_s4   <= sign_s3 ? acc_t'(15'd0 - {3'b000, lut_inc}) : acc_t'({3'b000, lut_inc});
        end
    end

endmodule

//--- design/adpcma_mixer.sv
// Outputs are one-clk strobes with no hold; the mix is valid only with mix_valid
`timescale 1ns/1ps
`include "adpcma_config.svh"

module adpcma_mixer
    import adpcma_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cen,
    input  slot_t   slot,
    input  sample_t pcm,
    output logic    ch_valid,
    output logic    mix_valid,
    output slot_t   ch_index,
    output sample_t ch_pcm,
    output sample_t mix
);

    localparam slot_t LAST_SLOT = slot_t'(`ADPCMA_NUM_CH - 1);
    // Headroom for six 16-bit terms
    localparam int SUM_W = `ADPCMA_PCM_W + 3;

    // pcm is fresh the clk after cen
    logic    cen_q;
    // Channel that pcm belongs to
    slot_t   cap_tag;
    // Channels 0..4 of the frame, 5 comes in live
    sample_t hist [`ADPCMA_NUM_CH-1];
    logic signed [SUM_W-1:0] frame_sum;
    sample_t frame_sat;

    // Slot already moved on, step back one
    assign cap_tag = (slot == '0) ? LAST_SLOT : slot - slot_t'(1);

    // Sum of the frame, incoming sample last
    always_comb begin
        frame_sum = {{3{pcm[`ADPCMA_PCM_W-1]}}, pcm};
        for (int i = 0; i < `ADPCMA_NUM_CH - 1; i++) begin
            frame_sum = frame_sum + {{3{hist[i][`ADPCMA_PCM_W-1]}}, hist[i]};
        end
        // Top bits disagree means out of range
        if (frame_sum[SUM_W-1:`ADPCMA_PCM_W-1] == '0 ||
            frame_sum[SUM_W-1:`ADPCMA_PCM_W-1] == '1) begin
            frame_sat = frame_sum[`ADPCMA_PCM_W-1:0];
        end else if (frame_sum[SUM_W-1]) begin
            frame_sat = 16'sh8000;
        end else begin
            frame_sat = 16'sh7fff;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_q     <= 1'b0;
            ch_valid  <= 1'b0;
            mix_valid <= 1'b0;
        end else begin
            cen_q     <= cen;
            ch_valid  <= cen_q;
            // End of frame
            mix_valid <= cen_q && (cap_tag == LAST_SLOT);
        end
    end

    // Sample and mix payload
    always_ff @(posedge clk) begin
        if (cen_q) begin
            ch_index <= cap_tag;
            ch_pcm   <= pcm;
            if (cap_tag != LAST_SLOT) begin
                hist[cap_tag] <= pcm;
            end else begin
                mix <= frame_sat;
            end
        end
    end

endmodule

//--- design/adpcma_pkg.sv
// Types only; widths come from the config header and assume the six-channel build
`include "adpcma_config.svh"

package adpcma_pkg;

    // Sign in bit 3, magnitude code in bits 2:0
    typedef logic [`ADPCMA_NIB_W-1:0] nibble_t;

    // Adaptive step index, 0 to 48
    typedef logic [`ADPCMA_STEP_W-1:0] step_idx_t;

    // Unsigned increment from the step table
    typedef logic [`ADPCMA_INC_W-1:0] inc_t;

    // Per-channel accumulator, two's complement
    typedef logic signed [`ADPCMA_ACC_W-1:0] acc_t;

    // Sign-extended accumulator, also the mix width
    typedef logic signed [`ADPCMA_PCM_W-1:0] sample_t;

    // Channel or slot number
    typedef logic [`ADPCMA_SLOT_W-1:0] slot_t;

endpackage

//--- design/adpcma_slot_seq.sv
// Host writes have no back-pressure; a newer write to a channel replaces any older pending one
`timescale 1ns/1ps
`include "adpcma_config.svh"

module adpcma_slot_seq
    import adpcma_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cen,
    input  logic    nib_wr,
    input  logic    key_on,
    input  slot_t   nib_ch,
    input  slot_t   key_ch,
    input  nibble_t nib_data,
    output slot_t   slot,
    output nibble_t dec_nib,
    output logic    dec_apply,
    output logic    dec_clr
);

    localparam slot_t LAST_SLOT = slot_t'(`ADPCMA_NUM_CH - 1);

    // Pending flags per channel
    logic [`ADPCMA_NUM_CH-1:0] nib_pend;
    logic [`ADPCMA_NUM_CH-1:0] clr_pend;
    // Buffered nibble payload
    nibble_t nib_buf [`ADPCMA_NUM_CH];

    // Current slot view for the decoder
    always_comb begin
        dec_nib   = nib_pend[slot] ? nib_buf[slot] : '0;
        dec_clr   = clr_pend[slot];
        // Clear takes priority, nibble waits a frame
        dec_apply = nib_pend[slot] & ~clr_pend[slot];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot     <= '0;
            nib_pend <= '0;
            clr_pend <= '0;
        end else begin
            if (cen) begin
                // Ring position 0..5
                slot <= (slot == LAST_SLOT) ? '0 : slot + slot_t'(1);
                // Retire what this visit consumed
                if (clr_pend[slot]) begin
                    clr_pend[slot] <= 1'b0;
                end else begin
                    nib_pend[slot] <= 1'b0;
                end
            end
            // New writes last, so a collision keeps them pending
            if (nib_wr) begin
                nib_pend[nib_ch] <= 1'b1;
            end
            if (key_on) begin
                clr_pend[key_ch] <= 1'b1;
            end
        end
    end

    // Nibble data, valid only under its flag
    always_ff @(posedge clk) begin
        if (nib_wr) begin
            nib_buf[nib_ch] <= nib_data;
        end
    end

endmodule

//--- design/adpcma_step_lut.sv
// Step indices above 48 read the top entry; output is registered on cen, one cen of latency
`timescale 1ns/1ps

module adpcma_step_lut
    import adpcma_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cen,
    input  step_idx_t step,
    input  logic [2:0] mag,
    output inc_t      inc
);

    // Largest size is 1552, fits 11 bits
    logic [10:0] step_size;
    // Odd multiplier 2m+1
    logic [3:0]  mult;
    // Size times multiplier before the divide by 8
    logic [14:0] prod;

    // Step-size table, 49 entries
    always_comb begin
        case (step)
            6'd0:    step_size = 11'd16;
            6'd1:    step_size = 11'd17;
            6'd2:    step_size = 11'd19;
            6'd3:    step_size = 11'd21;
            6'd4:    step_size = 11'd23;
            6'd5:    step_size = 11'd25;
            6'd6:    step_size = 11'd28;
            6'd7:    step_size = 11'd31;
            6'd8:    step_size = 11'd34;
            6'd9:    step_size = 11'd37;
            6'd10:   step_size = 11'd41;
            6'd11:   step_size = 11'd45;
            6'd12:   step_size = 11'd50;
            6'd13:   step_size = 11'd55;
            6'd14:   step_size = 11'd60;
            6'd15:   step_size = 11'd66;
            6'd16:   step_size = 11'd73;
            6'd17:   step_size = 11'd80;
            6'd18:   step_size = 11'd88;
            6'd19:   step_size = 11'd97;
            6'd20:   step_size = 11'd107;
            6'd21:   step_size = 11'd118;
            6'd22:   step_size = 11'd130;
            6'd23:   step_size = 11'd143;
            6'd24:   step_size = 11'd157;
            6'd25:   step_size = 11'd173;
            6'd26:   step_size = 11'd190;
            6'd27:   step_size = 11'd209;
            6'd28:   step_size = 11'd230;
            6'd29:   step_size = 11'd253;
            6'd30:   step_size = 11'd279;
            6'd31:   step_size = 11'd307;
            6'd32:   step_size = 11'd337;
            6'd33:   step_size = 11'd371;
            6'd34:   step_size = 11'd408;
            6'd35:   step_size = 11'd449;
            6'd36:   step_size = 11'd494;
            6'd37:   step_size = 11'd544;
            6'd38:   step_size = 11'd598;
            6'd39:   step_size = 11'd658;
            6'd40:   step_size = 11'd724;
            6'd41:   step_size = 11'd796;
            6'd42:   step_size = 11'd876;
            6'd43:   step_size = 11'd963;
            6'd44:   step_size = 11'd1060;
            6'd45:   step_size = 11'd1166;
            6'd46:   step_size = 11'd1282;
            6'd47:   step_size = 11'd1411;
            // Index 48 and anything past the clamp
            default: step_size = 11'd1552;
        endcase
    end

    // Increment is size * (2m+1) / 8, truncated
    always_comb begin
        mult = {mag, 1'b1};
        prod = 15'(step_size) * 15'(mult);
    end

    // Max 1552*15/8 = 2910, no loss in 12 bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inc <= '0;
        end else if (cen) begin
            inc <= prod[14:3];
        end
    end

endmodule

//--- design/adpcma_top.sv
// Host strobes need no cen alignment; ch_valid follows each cen by one clk
`timescale 1ns/1ps

module adpcma_top
    import adpcma_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cen,
    input  logic    nib_wr,
    input  logic    key_on,
    input  slot_t   nib_ch,
    input  slot_t   key_ch,
    input  nibble_t nib_data,
    output logic    ch_valid,
    output logic    mix_valid,
    output slot_t   ch_index,
    output sample_t ch_pcm,
    output sample_t mix
);

    // Sequencer to ring
    slot_t   slot;
    nibble_t dec_nib;
    logic    dec_apply;
    logic    dec_clr;
    // Ring stage II value
    sample_t pcm;

    adpcma_slot_seq u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .nib_wr    (nib_wr),
        .key_on    (key_on),
        .nib_ch    (nib_ch),
        .key_ch    (key_ch),
        .nib_data  (nib_data),
        .slot      (slot),
        .dec_nib   (dec_nib),
        .dec_apply (dec_apply),
        .dec_clr   (dec_clr)
    );

    adpcma_decoder u_dec (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .apply (dec_apply),
        .clr   (dec_clr),
        .nib   (dec_nib),
        .pcm   (pcm)
    );

    adpcma_mixer u_mix (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .slot      (slot),
        .pcm       (pcm),
        .ch_valid  (ch_valid),
        .mix_valid (mix_valid),
        .ch_index  (ch_index),
        .ch_pcm    (ch_pcm),
        .mix       (mix)
    );

endmodule

//--- project.f
+incdir+design
design/adpcma_pkg.sv
design/adpcma_step_lut.sv
design/adpcma_slot_seq.sv
design/adpcma_decoder.sv
design/adpcma_mixer.sv
design/adpcma_top.sv
verif/adpcma_tb.sv

//--- verif/adpcma_tb.sv
// Writes land one visit ahead of their channel, cen runs high, high, low; stops at the first error
`timescale 1ns/1ps
`include "adpcma_config.svh"

module adpcma_tb
    import adpcma_pkg::*;
();

    localparam int NUM_CH       = `ADPCMA_NUM_CH;
    localparam int STEP_MAX     = `ADPCMA_STEP_MAX;
    localparam int DIR_ROWS     = 12;
    localparam int RAND_ROWS    = 30;
    localparam int ROWS         = DIR_ROWS + RAND_ROWS;
    localparam int RESET_CYCLES = 16;
    // Each visit takes at most 3 clks, doubled for margin
    localparam int CYCLE_LIMIT  = ROWS * NUM_CH * 3 * 2 + RESET_CYCLES;

    // ADPCM-A step sizes, index 0 to 48
    localparam int STEP_SIZE [49] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66, 73,
        80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279,
        307, 337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963,
        1060, 1166, 1282, 1411, 1552
    };

    logic    clk;
    logic    rst_n;
    logic    cen;
    logic    nib_wr;
    logic    key_on;
    slot_t   nib_ch;
    slot_t   key_ch;
    nibble_t nib_data;
    logic    ch_valid;
    logic    mix_valid;
    slot_t   ch_index;
    sample_t ch_pcm;
    sample_t mix;

    // Stimulus table, one row per frame
    logic    tab_wr     [ROWS][NUM_CH];
    logic    tab_key    [ROWS][NUM_CH];
    nibble_t tab_nib    [ROWS][NUM_CH];
    logic    tab_exp_en [ROWS][NUM_CH];
    sample_t tab_exp    [ROWS][NUM_CH];

    // Reference model state
    int      m_step     [NUM_CH];
    acc_t    m_acc      [NUM_CH];
    logic    m_nib_pend [NUM_CH];
    nibble_t m_nib      [NUM_CH];
    logic    m_clr_pend [NUM_CH];

    // Expected outputs in visit order
    slot_t   exp_idx_q [$];
    sample_t exp_pcm_q [$];
    // Latest expected value per channel, for the mix
    sample_t frame_pcm [NUM_CH];

    integer seed;
    int     drv_cyc;
    int     cyc_cnt = 0;

    adpcma_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .nib_wr    (nib_wr),
        .key_on    (key_on),
        .nib_ch    (nib_ch),
        .key_ch    (key_ch),
        .nib_data  (nib_data),
        .ch_valid  (ch_valid),
        .mix_valid (mix_valid),
        .ch_index  (ch_index),
        .ch_pcm    (ch_pcm),
        .mix       (mix)
    );

    // 8 ns period
    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_sample(input string what, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_slot(input string what, input slot_t got, input slot_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // Step size times (2m+1), over 8
    function automatic int nib_increment(input int step, input nibble_t nib);
        int mag;
        mag = int'(nib[2:0]);
        return (STEP_SIZE[step] * (2 * mag + 1)) / 8;
    endfunction

    function automatic int next_step(input int step, input nibble_t nib);
        int s;
        case (nib[2:0])
            3'd4:    s = step + 2;
            3'd5:    s = step + 5;
            3'd6:    s = step + 7;
            3'd7:    s = step + 9;
            // Small codes walk down to 0
            default: s = (step > 0) ? step - 1 : 0;
        endcase
        if (s > STEP_MAX) begin
            s = STEP_MAX;
        end
        return s;
    endfunction

    function automatic sample_t saturated_mix();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_CH; i++) begin
            sum = sum + int'(frame_pcm[i]);
        end
        if (sum > 32767) begin
            sum = 32767;
        end else if (sum < -32768) begin
            sum = -32768;
        end
        return sample_t'(sum);
    endfunction

    // ch5 in the top nibble of nibs, ch0 in the bottom
    task automatic set_row(input int r, input logic [5:0] wr, input logic [23:0] nibs,
                           input logic [5:0] key);
        for (int c = 0; c < NUM_CH; c++) begin
            tab_wr[r][c]     = wr[c];
            tab_nib[r][c]    = nibs[4*c +: 4];
            tab_key[r][c]    = key[c];
            tab_exp_en[r][c] = 1'b0;
            tab_exp[r][c]    = '0;
        end
    endtask

    task automatic set_exp(input int r, input int c, input int val);
        tab_exp_en[r][c] = 1'b1;
        tab_exp[r][c]    = sample_t'(val);
    endtask

    task automatic random_row(input int r);
        logic [31:0] rnd;
        for (int c = 0; c < NUM_CH; c++) begin
            rnd              = $random(seed);
            // Write three times in four, key-on one in eight
            tab_wr[r][c]     = (rnd[1:0] != 2'b00);
            tab_nib[r][c]    = rnd[7:4];
            tab_key[r][c]    = (rnd[10:8] == 3'b000);
            tab_exp_en[r][c] = 1'b0;
            tab_exp[r][c]    = '0;
        end
    endtask

    task automatic build_table();
        // ch0 directed, ch1 sweeps codes, ch2..5 run 0x7 into clamp, wrap and saturation
        set_row(0,  6'b111111, 24'h777707, 6'b000000);
        set_row(1,  6'b111111, 24'h77778F, 6'b000000);
        set_row(2,  6'b111110, 24'h777710, 6'b000000);
        set_row(3,  6'b111111, 24'h777724, 6'b000001);
        set_row(4,  6'b111110, 24'h777730, 6'b000000);
        set_row(5,  6'b111110, 24'h777740, 6'b000000);
        set_row(6,  6'b111111, 24'h777750, 6'b000000);
        set_row(7,  6'b111110, 24'h777760, 6'b000001);
        set_row(8,  6'b111110, 24'h7777F0, 6'b000000);
        set_row(9,  6'b111110, 24'h7777B0, 6'b000000);
        set_row(10, 6'b111110, 24'h7777D0, 6'b000000);
        set_row(11, 6'b000000, 24'h000000, 6'b000000);
        for (int c = 0; c < NUM_CH; c++) begin
            set_exp(0, c, 0);
        end
        // ch0: 0x7, 0xF, hold, key-on with 0x4, hold, 0x0, key-on
        set_exp(1, 0, 30);
        set_exp(2, 0, -39);
        set_exp(3, 0, -39);
        set_exp(4, 0, 0);
        set_exp(5, 0, 18);
        set_exp(6, 0, 18);
        set_exp(7, 0, 20);
        set_exp(8, 0, 0);
        set_exp(9, 0, 0);
        // Step floor at 0
        set_exp(1, 1, 2);
        set_exp(2, 1, 0);
        set_exp(3, 1, 6);
        set_exp(4, 1, 16);
        set_exp(1, 2, 30);
        set_exp(2, 2, 99);
        set_exp(3, 2, 264);
        for (int r = DIR_ROWS; r < ROWS; r++) begin
            random_row(r);
        end
    endtask

    // Visit of one channel, value seen is from before this visit
    task automatic model_visit(input int row, input int ch);
        int acc_v;
        exp_idx_q.push_back(slot_t'(ch));
        if (tab_exp_en[row][ch]) begin
            exp_pcm_q.push_back(tab_exp[row][ch]);
        end else begin
            exp_pcm_q.push_back(sample_t'(m_acc[ch]));
        end
        if (m_clr_pend[ch]) begin
            // Clear first, nibble stays for the next visit
            m_acc[ch]      = '0;
            m_step[ch]     = 0;
            m_clr_pend[ch] = 1'b0;
        end else if (m_nib_pend[ch]) begin
            acc_v = int'(m_acc[ch]);
            if (m_nib[ch][3]) begin
                acc_v = acc_v - nib_increment(m_step[ch], m_nib[ch]);
            end else begin
                acc_v = acc_v + nib_increment(m_step[ch], m_nib[ch]);
            end
            // 15-bit wrap
            m_acc[ch]      = acc_t'(acc_v);
            m_step[ch]     = next_step(m_step[ch], m_nib[ch]);
            m_nib_pend[ch] = 1'b0;
        end
    endtask

    // Inputs change 1 ns after the edge, model follows what the next edge takes
    task automatic drive_cycle(input logic cen_v, input int vis_row, input int wr_row,
                               input int wr_ch);
        @(posedge clk);
        #1;
        cen    = cen_v;
        nib_wr = 1'b0;
        key_on = 1'b0;
        if (cen_v) begin
            model_visit(vis_row, (wr_ch + NUM_CH - 1) % NUM_CH);
        end
        if (wr_row >= 0) begin
            nib_wr   = tab_wr[wr_row][wr_ch];
            key_on   = tab_key[wr_row][wr_ch];
            nib_ch   = slot_t'(wr_ch);
            key_ch   = slot_t'(wr_ch);
            nib_data = tab_nib[wr_row][wr_ch];
            // Writes after the consume
            if (nib_wr) begin
                m_nib_pend[wr_ch] = 1'b1;
                m_nib[wr_ch]      = nib_data;
            end
            if (key_on) begin
                m_clr_pend[wr_ch] = 1'b1;
            end
        end
        drv_cyc = drv_cyc + 1;
    endtask

    // Each visit carries the writes for the next channel
    task automatic run_visit(input int row, input int ch);
        int nch;
        int nrow;
        nch  = (ch + 1) % NUM_CH;
        nrow = (nch == 0) ? row + 1 : row;
        if (nrow >= ROWS) begin
            nrow = -1;
        end
        // Gap clk of the cen pattern
        while (drv_cyc % 3 == 2) begin
            drive_cycle(1'b0, 0, -1, 0);
        end
        drive_cycle(1'b1, row, nrow, nch);
    endtask

    task automatic check_channel();
        slot_t   idx;
        sample_t val;
        idx = exp_idx_q.pop_front();
        val = exp_pcm_q.pop_front();
        check_slot("ch_index", ch_index, idx);
        check_sample("ch_pcm", ch_pcm, val);
        frame_pcm[idx] = val;
        // Mix only at the end of a frame
        check_flag("mix_valid", mix_valid, idx == slot_t'(NUM_CH - 1));
        if (idx == slot_t'(NUM_CH - 1)) begin
            check_sample("mix", mix, saturated_mix());
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (ch_valid === 1'b1) begin
            if (exp_idx_q.size() == 0) begin
                abort_run("ch_valid pulsed with no channel visit outstanding");
            end else begin
                check_channel();
            end
        end else if (mix_valid === 1'b1) begin
            abort_run("mix_valid pulsed without ch_valid");
        end
    end

    always @(posedge clk) begin
        cyc_cnt = cyc_cnt + 1;
        if (cyc_cnt >= CYCLE_LIMIT) begin
            abort_run("timeout, outputs stopped arriving");
        end
    end

    initial begin
        seed     = 17;
        drv_cyc  = 0;
        rst_n    = 1'b0;
        cen      = 1'b0;
        nib_wr   = 1'b0;
        key_on   = 1'b0;
        nib_ch   = '0;
        key_ch   = '0;
        nib_data = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            m_step[c]     = 0;
            m_acc[c]      = '0;
            m_nib_pend[c] = 1'b0;
            m_nib[c]      = '0;
            m_clr_pend[c] = 1'b0;
            frame_pcm[c]  = '0;
        end
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Writes for channel 0 of the first frame
        drive_cycle(1'b0, 0, 0, 0);
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < NUM_CH; c++) begin
                run_visit(r, c);
            end
        end
        // Let the last visits come out
        while (exp_idx_q.size() > 0) begin
            drive_cycle(1'b0, 0, -1, 0);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
